//--- addressUnit_defines.svh
`ifndef ADDRESS_UNIT_DEFINES_SVH
`define ADDRESS_UNIT_DEFINES_SVH

// address and bus width
`define ADDR_WIDTH 16

// counter reset values
`define PC_RESET   16'hE000  // boot vector
`define SP_RESET   16'hFFFF  // stack grows down from top of memory
`define MAR_RESET  16'h0000

`endif

//--- addressUnit_pkg.sv
`include "addressUnit_defines.svh"

package addressUnit_pkg;

    // one address word
    typedef logic [`ADDR_WIDTH-1:0] addrT;

    // address operations accepted by the unit
    typedef enum logic [3:0] {
        NOP          = 4'd0,
        LOAD_PC_EXT  = 4'd1,
        LOAD_SP_EXT  = 4'd2,
        LOAD_MAR_EXT = 4'd3,
        INC_PC       = 4'd4,
        INC_SP       = 4'd5,
        DEC_SP       = 4'd6,
        MAR_FROM_PC  = 4'd7,
        MAR_FROM_SP  = 4'd8,
        PC_FROM_MAR  = 4'd9
    } addrOpT;

    // data only matters for the external loads
    typedef struct packed {
        addrOpT op;
        addrT   data;
    } addrReqT;

    // per-counter control strobes for one cycle
    typedef struct packed {
        logic load;    // primary takes the bus
        logic up;      // primary + 1
        logic down;    // primary - 1
        logic commit;  // output stage copies primary
    } counterCmdT;

    // who drives the internal address bus
    typedef enum logic [2:0] {
        NONE = 3'd0,
        EXT  = 3'd1,
        PC   = 3'd2,
        SP   = 3'd3,
        MAR  = 3'd4
    } busSrcT;

endpackage

//--- addressCounter.sv
// two-stage address counter
//
// The primary stage reacts to load/up/down. The output stage only follows
// the primary when commit is strobed, so a change is not visible on addr
// until the cycle after it was made.
module addressCounter #(
    parameter addressUnit_pkg::addrT RESET_VALUE = '0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  addressUnit_pkg::counterCmdT cmd,
    input  addressUnit_pkg::addrT      loadValue,
    output addressUnit_pkg::addrT      addr
);

    import addressUnit_pkg::*;

    addrT primary;      // working stage
    addrT outputStage;  // committed value seen by the rest of the cpu
    addrT primaryNext;
    logic primaryEn;

    // next primary value, load wins over up, up over down
    always_comb begin
        primaryNext = primary;
        primaryEn   = 1'b0;
        if (cmd.load) begin
            primaryNext = loadValue;
            primaryEn   = 1'b1;
        end else if (cmd.up) begin
            primaryNext = primary + addrT'(1);  // wraps at FFFF
            primaryEn   = 1'b1;
        end else if (cmd.down) begin
            primaryNext = primary - addrT'(1);  // wraps at 0
            primaryEn   = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            primary <= RESET_VALUE;
        end else if (primaryEn) begin
            primary <= primaryNext;
        end
    end

    // second stage, stands in for the old iclk latch
    always_ff @(posedge clk) begin
        if (rst) begin
            outputStage <= RESET_VALUE;
        end else if (cmd.commit) begin
            outputStage <= primary;
        end
    end

    assign addr = outputStage;

endmodule

//--- addressSequencer.sv
// address operation sequencer
//
// Takes one request at a time and walks it through three phases:
//   IDLE   ready for a new request
//   EXEC   bus driven, target gets its load/up/down strobe
//   COMMIT target copies primary into its output stage
module addressSequencer (
    input  logic                        clk,
    input  logic                        rst,
    input  addressUnit_pkg::addrReqT    req,
    input  logic                        reqValid,
    output logic                        reqReady,
    input  addressUnit_pkg::addrT       pcAddr,
    input  addressUnit_pkg::addrT       spAddr,
    input  addressUnit_pkg::addrT       marAddr,
    output addressUnit_pkg::counterCmdT pcCmd,
    output addressUnit_pkg::counterCmdT spCmd,
    output addressUnit_pkg::counterCmdT marCmd,
    output addressUnit_pkg::addrT       bus,
    output logic                        busValid
);

    import addressUnit_pkg::*;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        EXEC   = 2'd1,
        COMMIT = 2'd2
    } phaseT;

    phaseT      phase;
    addrReqT    heldReq;   // request in flight
    busSrcT     busSrc;    // decoded bus driver
    busSrcT     target;    // decoded target counter, NONE for NOP
    counterCmdT strobe;    // load/up/down for the target, commit unused here
    addrT       busMux;
    logic       accept;

    assign reqReady = (phase == IDLE);
    assign accept   = reqValid && reqReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= IDLE;
        end else begin
            case (phase)
                IDLE:    if (accept) phase <= EXEC;
                EXEC:    phase <= COMMIT;
                COMMIT:  phase <= IDLE;
                default: phase <= IDLE;
            endcase
        end
    end

    // request payload, only captured on a handshake
    always_ff @(posedge clk) begin
        if (accept) begin
            heldReq <= req;
        end
    end

    // operation decode
    always_comb begin
        busSrc = NONE;
        target = NONE;
        strobe = '0;
        case (heldReq.op)
            LOAD_PC_EXT: begin
                busSrc      = EXT;
                target      = PC;
                strobe.load = 1'b1;
            end
            LOAD_SP_EXT: begin
                busSrc      = EXT;
                target      = SP;
                strobe.load = 1'b1;
            end
            LOAD_MAR_EXT: begin
                busSrc      = EXT;
                target      = MAR;
                strobe.load = 1'b1;
            end
            INC_PC: begin
                target    = PC;
                strobe.up = 1'b1;
            end
            INC_SP: begin
                target    = SP;
                strobe.up = 1'b1;
            end
            DEC_SP: begin
                target      = SP;
                strobe.down = 1'b1;
            end
            MAR_FROM_PC: begin
                busSrc      = PC;
                target      = MAR;
                strobe.load = 1'b1;
            end
            MAR_FROM_SP: begin
                busSrc      = SP;
                target      = MAR;
                strobe.load = 1'b1;
            end
            PC_FROM_MAR: begin
                busSrc      = MAR;
                target      = PC;
                strobe.load = 1'b1;
            end
            default: ;  // NOP, nothing moves
        endcase
    end

    // bus multiplexer, copies always see committed values
    always_comb begin
        case (busSrc)
            EXT:     busMux = heldReq.data;
            PC:      busMux = pcAddr;
            SP:      busMux = spAddr;
            MAR:     busMux = marAddr;
            default: busMux = '0;
        endcase
    end

    assign busValid = (phase == EXEC) && (busSrc != NONE);
    assign bus      = busValid ? busMux : '0;

    // strobe in EXEC, commit in COMMIT, only for the selected counter
    function automatic counterCmdT cmdFor(
        busSrcT     who,
        busSrcT     sel,
        phaseT      ph,
        counterCmdT stb
    );
        counterCmdT c;
        c = '0;
        if (sel == who) begin
            if (ph == EXEC) begin
                c        = stb;
                c.commit = 1'b0;
            end else if (ph == COMMIT) begin
                c.commit = 1'b1;
            end
        end
        return c;
    endfunction

    assign pcCmd  = cmdFor(PC,  target, phase, strobe);
    assign spCmd  = cmdFor(SP,  target, phase, strobe);
    assign marCmd = cmdFor(MAR, target, phase, strobe);

endmodule

//--- addressUnit.sv
`include "addressUnit_defines.svh"

// address unit top: one sequencer driving PC, SP and MAR counters
module addressUnit (
    input  logic                     clk,
    input  logic                     rst,
    input  addressUnit_pkg::addrReqT req,
    input  logic                     reqValid,
    output logic                     reqReady,
    output logic                     busValid,
    output addressUnit_pkg::addrT    bus,
    output addressUnit_pkg::addrT    pcAddr,
    output addressUnit_pkg::addrT    spAddr,
    output addressUnit_pkg::addrT    marAddr
);

    import addressUnit_pkg::*;

    counterCmdT pcCmd;
    counterCmdT spCmd;
    counterCmdT marCmd;

    addressSequencer sequencer (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .reqValid (reqValid),
        .reqReady (reqReady),
        .pcAddr   (pcAddr),
        .spAddr   (spAddr),
        .marAddr  (marAddr),
        .pcCmd    (pcCmd),
        .spCmd    (spCmd),
        .marCmd   (marCmd),
        .bus      (bus),
        .busValid (busValid)
    );

    // all counters load from the internal bus
    addressCounter #(
        .RESET_VALUE (addrT'(`PC_RESET))
    ) pcCounter (
        .clk       (clk),
        .rst       (rst),
        .cmd       (pcCmd),
        .loadValue (bus),
        .addr      (pcAddr)
    );

    addressCounter #(
        .RESET_VALUE (addrT'(`SP_RESET))
    ) spCounter (
        .clk       (clk),
        .rst       (rst),
        .cmd       (spCmd),
        .loadValue (bus),
        .addr      (spAddr)
    );

    addressCounter #(
        .RESET_VALUE (addrT'(`MAR_RESET))
    ) marCounter (
        .clk       (clk),
        .rst       (rst),
        .cmd       (marCmd),
        .loadValue (bus),
        .addr      (marAddr)
    );

endmodule

//--- addressUnit_sva.sv
module addressUnit_sva (
    input logic                        clk,
    input logic                        rst,
    input logic                        reqReady,
    input addressUnit_pkg::counterCmdT pcCmd,
    input addressUnit_pkg::counterCmdT spCmd,
    input addressUnit_pkg::counterCmdT marCmd
);

    int   assertFails = 0;  // failed assertions so far
    logic pcStrobe;
    logic spStrobe;
    logic marStrobe;
    logic anyCommit;

    assign pcStrobe  = pcCmd.load | pcCmd.up | pcCmd.down;
    assign spStrobe  = spCmd.load | spCmd.up | spCmd.down;
    assign marStrobe = marCmd.load | marCmd.up | marCmd.down;
    assign anyCommit = pcCmd.commit | spCmd.commit | marCmd.commit;

    // commit comes exactly one cycle after the strobe, never otherwise
    property commitTiming(logic strobe, logic commit);
        @(posedge clk) disable iff (rst)
            (strobe |=> commit) and (commit |-> $past(strobe));
    endproperty

    pcCommit: assert property (commitTiming(pcStrobe, pcCmd.commit))
        else begin
            $error("pc commit out of step with its strobe");
            assertFails++;
        end
    spCommit: assert property (commitTiming(spStrobe, spCmd.commit))
        else begin
            $error("sp commit out of step with its strobe");
            assertFails++;
        end
    marCommit: assert property (commitTiming(marStrobe, marCmd.commit))
        else begin
            $error("mar commit out of step with its strobe");
            assertFails++;
        end

    busyNotReady: assert property (@(posedge clk) disable iff (rst)
        (pcStrobe | spStrobe | marStrobe | anyCommit) |-> !reqReady)
        else begin
            $error("reqReady high while an operation is in flight");
            assertFails++;
        end

    oneTarget: assert property (@(posedge clk) disable iff (rst)
        $onehot0({pcStrobe, spStrobe, marStrobe}))
        else begin
            $error("more than one counter strobed");
            assertFails++;
        end

endmodule

bind addressSequencer addressUnit_sva sequencerSva (
    .clk      (clk),
    .rst      (rst),
    .reqReady (reqReady),
    .pcCmd    (pcCmd),
    .spCmd    (spCmd),
    .marCmd   (marCmd)
);

//--- addressUnit_tb.sv
`include "addressUnit_defines.svh"

module addressUnit_tb;

    import addressUnit_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 16;
    localparam int BURST_OPS       = 12;
    localparam int NUM_OPS         = 43;  // operations issued over all tests
    localparam int MARGIN_CYCLES   = 100;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 3 + RESET_CYCLES + MARGIN_CYCLES;

    logic    clk;
    logic    rst;
    addrReqT req;
    logic    reqValid;
    logic    reqReady;
    logic    busValid;
    addrT    bus;
    addrT    pcAddr;
    addrT    spAddr;
    addrT    marAddr;

    // committed counter values as the rules predict them
    addrT modelPc;
    addrT modelSp;
    addrT modelMar;

    int unsigned lcgState    = 79608;
    int          errorCount  = 0;
    int          testCount   = 0;
    int          failedTests = 0;
    int          acceptCount = 0;

    addressUnit addressUnit_i (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .reqValid (reqValid),
        .reqReady (reqReady),
        .busValid (busValid),
        .bus      (bus),
        .pcAddr   (pcAddr),
        .spAddr   (spAddr),
        .marAddr  (marAddr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // handshakes seen by the DUT
    always @(posedge clk) begin
        if (!rst && reqValid && reqReady) begin
            acceptCount <= acceptCount + 1;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic addrT randAddr();
        logic [31:0] r;
        r = nextRand();
        return r[31:16];  // upper bits are the better ones
    endfunction

    function automatic addrOpT randAnyOp();
        logic [31:0] r;
        r = nextRand() % 32'd10;
        return addrOpT'(r[3:0]);
    endfunction

    // bus value during EXEC, from the committed model values
    function automatic addrT busExpected(input addrOpT op, input addrT data);
        case (op)
            LOAD_PC_EXT, LOAD_SP_EXT, LOAD_MAR_EXT: return data;
            MAR_FROM_PC: return modelPc;
            MAR_FROM_SP: return modelSp;
            PC_FROM_MAR: return modelMar;
            default:     return '0;
        endcase
    endfunction

    function automatic logic busUsed(input addrOpT op);
        return !(op inside {NOP, INC_PC, INC_SP, DEC_SP});
    endfunction

    task automatic applyModel(input addrOpT op, input addrT data);
        case (op)
            LOAD_PC_EXT:  modelPc  = data;
            LOAD_SP_EXT:  modelSp  = data;
            LOAD_MAR_EXT: modelMar = data;
            INC_PC:       modelPc  = modelPc + 16'd1;
            INC_SP:       modelSp  = modelSp + 16'd1;
            DEC_SP:       modelSp  = modelSp - 16'd1;
            MAR_FROM_PC:  modelMar = modelPc;
            MAR_FROM_SP:  modelMar = modelSp;
            PC_FROM_MAR:  modelPc  = modelMar;
            default: ;
        endcase
    endtask

    task automatic compareAddr(input string name, input addrT actual, input addrT expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic compareBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkCounters();
        compareAddr("pcAddr", pcAddr, modelPc);
        compareAddr("spAddr", spAddr, modelSp);
        compareAddr("marAddr", marAddr, modelMar);
    endtask

    task automatic waitReady();
        while (!reqReady) @(negedge clk);
    endtask

    // called on a falling edge, returns on the falling edge in EXEC
    task automatic sendOp(input addrOpT op, input addrT data, input logic hold);
        req.op   = op;
        req.data = data;
        reqValid = 1'b1;
        waitReady();
        @(posedge clk);
        applyModel(op, data);
        @(negedge clk);
        if (!hold) begin
            reqValid = 1'b0;
        end
    endtask

    task automatic runOp(input addrOpT op, input addrT data);
        addrT expBus;
        logic expValid;
        expBus   = busExpected(op, data);
        expValid = busUsed(op);
        sendOp(op, data, 1'b0);
        compareBit("busValid", busValid, expValid);
        compareAddr("bus", bus, expBus);
        waitReady();
        checkCounters();
    endtask

    task automatic finishTest(input string name, input int errorsAtStart);
        testCount++;
        if (errorCount == errorsAtStart) begin
            $display("test %s ok", name);
        end else begin
            failedTests++;
            $display("test %s failed with %0d errors", name, errorCount - errorsAtStart);
        end
    endtask

    task automatic resetTest();
        int e0;
        e0 = errorCount;
        compareAddr("pcAddr", pcAddr, `PC_RESET);
        compareAddr("spAddr", spAddr, `SP_RESET);
        compareAddr("marAddr", marAddr, `MAR_RESET);
        compareBit("reqReady", reqReady, 1'b1);
        compareBit("busValid", busValid, 1'b0);
        finishTest("reset", e0);
    endtask

    // walks LOAD_PC_EXT edge by edge
    task automatic twoStageTest();
        int   e0;
        addrT data;
        addrT oldPc;
        e0    = errorCount;
        oldPc = modelPc;
        data  = randAddr();
        if (data == oldPc) begin
            data = ~data;
        end
        sendOp(LOAD_PC_EXT, data, 1'b0);  // now in EXEC
        compareAddr("bus", bus, data);
        compareBit("busValid", busValid, 1'b1);
        compareBit("reqReady", reqReady, 1'b0);
        compareAddr("pcAddr", pcAddr, oldPc);
        @(negedge clk);  // COMMIT, primary updated but not yet visible
        compareAddr("pcAddr", pcAddr, oldPc);
        compareBit("busValid", busValid, 1'b0);
        compareBit("reqReady", reqReady, 1'b0);
        @(negedge clk);
        compareAddr("pcAddr", pcAddr, data);
        compareBit("reqReady", reqReady, 1'b1);
        checkCounters();
        finishTest("twoStage", e0);
    endtask

    task automatic countTest();
        int          e0;
        logic [31:0] pick;
        e0 = errorCount;
        for (int i = 0; i < 20; i++) begin
            pick = nextRand() % 32'd3;
            case (pick)
                0:       runOp(INC_PC, randAddr());
                1:       runOp(INC_SP, randAddr());
                default: runOp(DEC_SP, randAddr());
            endcase
        end
        runOp(LOAD_PC_EXT, 16'hFFFF);
        runOp(INC_PC, '0);
        compareAddr("pcAddr", pcAddr, 16'h0000);  // wrap up
        runOp(LOAD_SP_EXT, 16'h0000);
        runOp(DEC_SP, '0);
        compareAddr("spAddr", spAddr, 16'hFFFF);  // wrap down
        finishTest("count", e0);
    endtask

    task automatic copyTest();
        int e0;
        e0 = errorCount;
        runOp(LOAD_PC_EXT, randAddr());
        runOp(LOAD_SP_EXT, randAddr());
        runOp(MAR_FROM_PC, randAddr());  // data must be ignored
        runOp(MAR_FROM_SP, randAddr());
        runOp(LOAD_MAR_EXT, randAddr());
        runOp(PC_FROM_MAR, randAddr());
        finishTest("copy", e0);
    endtask

    // reqValid stays high across the whole burst
    task automatic backPressureTest();
        int e0;
        int startAccepts;
        e0           = errorCount;
        startAccepts = acceptCount;
        for (int i = 0; i < BURST_OPS; i++) begin
            sendOp(randAnyOp(), randAddr(), i != BURST_OPS - 1);
        end
        waitReady();
        checkCounters();
        if (acceptCount - startAccepts != BURST_OPS) begin
            $display("error: %0d operations sent but the DUT accepted %0d",
                     BURST_OPS, acceptCount - startAccepts);
            errorCount++;
        end
        finishTest("backPressure", e0);
    endtask

    initial begin
        int svaFails;
        rst      = 1'b1;
        reqValid = 1'b0;
        req      = '0;
        modelPc  = `PC_RESET;
        modelSp  = `SP_RESET;
        modelMar = `MAR_RESET;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        resetTest();
        twoStageTest();
        countTest();
        copyTest();
        backPressureTest();

        svaFails = addressUnit_i.sequencer.sequencerSva.assertFails;
        if (svaFails != 0) begin
            $display("error: %0d assertion failures in the sequencer", svaFails);
        end
        $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
                 testCount, failedTests, errorCount, svaFails);
        if (errorCount == 0 && svaFails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+.
addressUnit_pkg.sv
addressCounter.sv
addressSequencer.sv
addressUnit.sv
addressUnit_sva.sv
addressUnit_tb.sv
